// File: soc_pkg.sv
// Address prefixes, register maps, bus request and response structs
`default_nettype none

package soc_pkg;

  // --------------------------------------------------
  // Memory map
  // --------------------------------------------------
  typedef enum logic [1:0] {
    AREA_ROM      = 2'h0,
    AREA_RAM      = 2'h1,
    AREA_RESERVED = 2'h2,
    AREA_MMIO     = 2'h3
  } area_e;

  typedef enum logic [5:0] {
    CORE_TIMER    = 6'h01,
    CORE_FW_RAM   = 6'h10,
    CORE_SYS_CTRL = 6'h3f
  } core_e;

  // Word address width seen by a core, wide enough for the app RAM
  localparam int CORE_AW = 16;

  // Register word addresses
  typedef enum logic [7:0] {
    TMR_CTRL      = 8'h08,
    TMR_STATUS    = 8'h09,
    TMR_PRESCALER = 8'h0a,
    TMR_TIMER     = 8'h0b
  } timer_reg_e;

  typedef enum logic [7:0] {
    SYS_REG_NAME     = 8'h00,
    SYS_REG_APP_MODE = 8'h08,
    SYS_REG_ADDR_KEY = 8'h10,
    SYS_REG_DATA_KEY = 8'h11
  } sys_reg_e;

  localparam logic [31:0] SYS_NAME      = 32'h736f_6331;
  localparam logic [31:0] ILLEGAL_INSTR = 32'h0000_0000;

  // --------------------------------------------------
  // Bus structs
  // --------------------------------------------------
  typedef struct packed {
    logic        valid;
    logic        instr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic               cs;
    logic [3:0]         we;
    logic [CORE_AW-1:0] address;
    logic [31:0]        write_data;
  } core_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] read_data;
  } core_rsp_t;

endpackage

`default_nettype wire

// File: mem_bus_ctrl.sv
// Bus decode controller: core selects, RAM scrambling, registered response mux
`timescale 1ns/10ps
`default_nettype none

module mem_bus_ctrl
  import soc_pkg::*;
#(
  parameter int RAM_AW = 10
) (
  input  wire              clk,
  input  wire              reset_n,
  input  wire mem_req_t    bus_req,
  input  wire              force_trap,
  input  wire [RAM_AW-1:0] addr_key,
  input  wire [31:0]       data_key,
  input  wire core_rsp_t   ram_rsp,
  input  wire core_rsp_t   fw_rsp,
  input  wire core_rsp_t   timer_rsp,
  input  wire core_rsp_t   sys_rsp,
  output mem_rsp_t         bus_rsp,
  output core_req_t        ram_req,
  output core_req_t        fw_req,
  output core_req_t        timer_req,
  output core_req_t        sys_req
);

  mem_rsp_t          rsp_next;
  core_req_t         base_req;
  logic [31:0]       addr_mask;
  logic [RAM_AW-1:0] ram_word_addr;

  // Address dependent data mask and scrambled RAM word address
  assign addr_mask     = {2{bus_req.addr[15:0]}};
  assign ram_word_addr = bus_req.addr[RAM_AW+1:2] ^ addr_key;

  // --------------------------------------------------
  // Response register
  // --------------------------------------------------
  always_ff @(posedge clk) begin : rsp_reg
    if (!reset_n) begin
      bus_rsp <= '0;
    end else begin
      bus_rsp <= rsp_next;
    end
  end

  // --------------------------------------------------
  // Decode and response mux
  // --------------------------------------------------
  always_comb begin : decode
    area_e area;
    core_e core;

    area = area_e'(bus_req.addr[31:30]);
    core = core_e'(bus_req.addr[29:24]);

    base_req            = '0;
    base_req.we         = bus_req.wstrb;
    base_req.address    = bus_req.addr[CORE_AW+1:2];
    base_req.write_data = bus_req.wdata;

    fw_req    = base_req;
    timer_req = base_req;
    sys_req   = base_req;

    // RAM sees the scrambled address and data
    ram_req            = base_req;
    ram_req.address    = CORE_AW'(ram_word_addr);
    ram_req.write_data = bus_req.wdata ^ data_key ^ addr_mask;

    rsp_next = '0;

    if (bus_req.valid && !bus_rsp.ready) begin
      if (force_trap) begin
        rsp_next.ready = 1'b1;
        rsp_next.rdata = ILLEGAL_INSTR;
      end else begin
        case (area)
          AREA_RAM: begin
            ram_req.cs     = 1'b1;
            rsp_next.ready = ram_rsp.ready;
            rsp_next.rdata = ram_rsp.read_data ^ data_key ^ addr_mask;
          end

          AREA_MMIO: begin
            case (core)
              CORE_TIMER: begin
                timer_req.cs   = 1'b1;
                rsp_next.ready = timer_rsp.ready;
                rsp_next.rdata = timer_rsp.read_data;
              end
              CORE_FW_RAM: begin
                fw_req.cs      = 1'b1;
                rsp_next.ready = fw_rsp.ready;
                rsp_next.rdata = fw_rsp.read_data;
              end
              CORE_SYS_CTRL: begin
                sys_req.cs     = 1'b1;
                rsp_next.ready = sys_rsp.ready;
                rsp_next.rdata = sys_rsp.read_data;
              end
              default: begin
                rsp_next.ready = 1'b1;
              end
            endcase
          end

          // ROM and reserved areas answer at once with zero
          default: begin
            rsp_next.ready = 1'b1;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: app_ram.sv
// Word RAM with byte strobes, registered read and one-cycle ready
`timescale 1ns/10ps
`default_nettype none

module app_ram
  import soc_pkg::*;
#(
  parameter int RAM_AW = 10
) (
  input  wire            clk,
  input  wire            reset_n,
  input  wire core_req_t req,
  output core_rsp_t      rsp
);

  logic [31:0]       mem [0:(1 << RAM_AW) - 1];
  logic [RAM_AW-1:0] word_addr;
  logic [31:0]       rdata_reg;
  logic              ready_reg;
  logic              first;

  assign word_addr = req.address[RAM_AW-1:0];
  // First cycle of a select, the only one that may write
  assign first     = req.cs && !ready_reg;

  always_ff @(posedge clk) begin : mem_port
    if (first) begin
      for (int i = 0; i < 4; i++) begin
        if (req.we[i]) begin
          mem[word_addr][8*i +: 8] <= req.write_data[8*i +: 8];
        end
      end
    end
    rdata_reg <= mem[word_addr];
  end

  always_ff @(posedge clk) begin : ready_gen
    if (!reset_n) begin
      ready_reg <= 1'b0;
    end else begin
      ready_reg <= first;
    end
  end

  assign rsp = '{ready: ready_reg, read_data: rdata_reg};

endmodule

`default_nettype wire

// File: fw_ram.sv
// Firmware RAM, write locked and read blanked in application mode
`timescale 1ns/10ps
`default_nettype none

module fw_ram
  import soc_pkg::*;
#(
  parameter int FW_AW = 7
) (
  input  wire            clk,
  input  wire            reset_n,
  input  wire            app_mode,
  input  wire core_req_t req,
  output core_rsp_t      rsp
);

  core_req_t store_req;
  core_rsp_t store_rsp;

  // Strip the strobes once application mode is set
  always_comb begin : lock
    store_req = req;
    if (app_mode) begin
      store_req.we = 4'h0;
    end
  end

  app_ram #(
    .RAM_AW(FW_AW)
  ) store_inst (
    .clk(clk),
    .reset_n(reset_n),
    .req(store_req),
    .rsp(store_rsp)
  );

  // Ready still comes back so the bus never stalls
  assign rsp.ready     = store_rsp.ready;
  assign rsp.read_data = app_mode ? 32'h0 : store_rsp.read_data;

endmodule

`default_nettype wire

// File: timer.sv
// Down-counting timer with prescaler, start/stop control and status
`timescale 1ns/10ps
`default_nettype none

module timer
  import soc_pkg::*;
(
  input  wire            clk,
  input  wire            reset_n,
  input  wire core_req_t req,
  output core_rsp_t      rsp
);

  logic        ready_reg;
  logic [31:0] rdata_reg;
  logic [31:0] rdata_next;
  logic        first;
  logic        write;
  logic        running;
  logic [31:0] prescaler;
  logic [31:0] pre_ctr;
  logic [31:0] count;

  assign first = req.cs && !ready_reg;
  assign write = first && (|req.we);

  // --------------------------------------------------
  // Counter and registers
  // --------------------------------------------------
  always_ff @(posedge clk) begin : reg_update
    if (!reset_n) begin
      running   <= 1'b0;
      prescaler <= '0;
      pre_ctr   <= '0;
      count     <= '0;
    end else begin
      if (running) begin
        if (count == 32'h0) begin
          running <= 1'b0;
        end else if (pre_ctr == prescaler) begin
          pre_ctr <= '0;
          count   <= count - 32'h1;
        end else begin
          pre_ctr <= pre_ctr + 32'h1;
        end
      end

      // Bus writes take priority over counting
      if (write) begin
        case (req.address[7:0])
          TMR_CTRL: begin
            if (req.write_data[0]) begin
              running <= 1'b1;
              pre_ctr <= '0;
            end
            if (req.write_data[1]) begin
              running <= 1'b0;
            end
          end
          TMR_PRESCALER: prescaler <= req.write_data;
          TMR_TIMER:     count     <= req.write_data;
          default: ;
        endcase
      end
    end
  end

  always_comb begin : read_mux
    rdata_next = 32'h0;
    case (req.address[7:0])
      TMR_STATUS:    rdata_next = {31'h0, running};
      TMR_PRESCALER: rdata_next = prescaler;
      TMR_TIMER:     rdata_next = count;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin : rsp_reg
    if (!reset_n) begin
      ready_reg <= 1'b0;
    end else begin
      ready_reg <= first;
    end
    rdata_reg <= rdata_next;
  end

  assign rsp = '{ready: ready_reg, read_data: rdata_reg};

endmodule

`default_nettype wire

// File: sys_ctrl.sv
// System control: application mode latch, scramble keys, name and forced trap
`timescale 1ns/10ps
`default_nettype none

module sys_ctrl
  import soc_pkg::*;
#(
  parameter int RAM_AW = 10
) (
  input  wire               clk,
  input  wire               reset_n,
  input  wire mem_req_t     bus_req,
  input  wire core_req_t    req,
  output core_rsp_t         rsp,
  output logic              app_mode,
  output logic [RAM_AW-1:0] addr_key,
  output logic [31:0]       data_key,
  output logic              force_trap
);

  logic        ready_reg;
  logic [31:0] rdata_reg;
  logic [31:0] rdata_next;
  logic        first;
  logic        write;

  assign first = req.cs && !ready_reg;
  assign write = first && (|req.we);

  // Fetch from anywhere but RAM once the app runs
  assign force_trap = bus_req.valid && bus_req.instr && app_mode &&
                      (bus_req.addr[31:30] != AREA_RAM);

  // --------------------------------------------------
  // Mode and key registers
  // --------------------------------------------------
  always_ff @(posedge clk) begin : reg_update
    if (!reset_n) begin
      app_mode <= 1'b0;
      addr_key <= '0;
      data_key <= '0;
    end else if (write) begin
      case (req.address[7:0])
        // Sticky until reset
        SYS_REG_APP_MODE: app_mode <= 1'b1;
        SYS_REG_ADDR_KEY: begin
          if (!app_mode) begin
            addr_key <= req.write_data[RAM_AW-1:0];
          end
        end
        SYS_REG_DATA_KEY: begin
          if (!app_mode) begin
            data_key <= req.write_data;
          end
        end
        default: ;
      endcase
    end
  end

  always_comb begin : read_mux
    rdata_next = 32'h0;
    case (req.address[7:0])
      SYS_REG_NAME:     rdata_next = SYS_NAME;
      SYS_REG_APP_MODE: rdata_next = {31'h0, app_mode};
      // Keys hidden from the application
      SYS_REG_ADDR_KEY: rdata_next = app_mode ? 32'h0 : 32'(addr_key);
      SYS_REG_DATA_KEY: rdata_next = app_mode ? 32'h0 : data_key;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin : rsp_reg
    if (!reset_n) begin
      ready_reg <= 1'b0;
    end else begin
      ready_reg <= first;
    end
    rdata_reg <= rdata_next;
  end

  assign rsp = '{ready: ready_reg, read_data: rdata_reg};

endmodule

`default_nettype wire

// File: soc_top.sv
// SoC fabric top: bus controller, application RAM, firmware RAM, timer, system control
`timescale 1ns/10ps
`default_nettype none

module soc_top
  import soc_pkg::*;
#(
  parameter int RAM_AW = 10,
  parameter int FW_AW  = 7
) (
  input  wire           clk,
  input  wire           reset_n,
  input  wire mem_req_t bus_req,
  output wire mem_rsp_t bus_rsp,
  output wire           app_mode
);

  core_req_t         ram_req;
  core_req_t         fw_req;
  core_req_t         timer_req;
  core_req_t         sys_req;
  core_rsp_t         ram_rsp;
  core_rsp_t         fw_rsp;
  core_rsp_t         timer_rsp;
  core_rsp_t         sys_rsp;
  logic              force_trap;
  logic [RAM_AW-1:0] addr_key;
  logic [31:0]       data_key;

  // --------------------------------------------------
  // Bus controller
  // --------------------------------------------------
  mem_bus_ctrl #(
    .RAM_AW(RAM_AW)
  ) ctrl_inst (
    .clk(clk),
    .reset_n(reset_n),
    .bus_req(bus_req),
    .force_trap(force_trap),
    .addr_key(addr_key),
    .data_key(data_key),
    .ram_rsp(ram_rsp),
    .fw_rsp(fw_rsp),
    .timer_rsp(timer_rsp),
    .sys_rsp(sys_rsp),
    .bus_rsp(bus_rsp),
    .ram_req(ram_req),
    .fw_req(fw_req),
    .timer_req(timer_req),
    .sys_req(sys_req)
  );

  // --------------------------------------------------
  // Cores
  // --------------------------------------------------
  app_ram #(
    .RAM_AW(RAM_AW)
  ) ram_inst (
    .clk(clk),
    .reset_n(reset_n),
    .req(ram_req),
    .rsp(ram_rsp)
  );

  fw_ram #(
    .FW_AW(FW_AW)
  ) fw_ram_inst (
    .clk(clk),
    .reset_n(reset_n),
    .app_mode(app_mode),
    .req(fw_req),
    .rsp(fw_rsp)
  );

  timer timer_inst (
    .clk(clk),
    .reset_n(reset_n),
    .req(timer_req),
    .rsp(timer_rsp)
  );

  sys_ctrl #(
    .RAM_AW(RAM_AW)
  ) sys_inst (
    .clk(clk),
    .reset_n(reset_n),
    .bus_req(bus_req),
    .req(sys_req),
    .rsp(sys_rsp),
    .app_mode(app_mode),
    .addr_key(addr_key),
    .data_key(data_key),
    .force_trap(force_trap)
  );

endmodule

`default_nettype wire

// File: tb_soc_model.svh
// Reference model: RAM contents, scramble keys, mode, register map and timer bound
`ifndef TB_SOC_MODEL_SVH
`define TB_SOC_MODEL_SVH

// Stored words by physical index, scrambled form for the app RAM
logic [31:0]       app_mem [int];
logic [31:0]       fw_mem [int];
logic [RAM_AW-1:0] m_addr_key;
logic [31:0]       m_data_key;
logic              m_app_mode;

task automatic model_reset();
  app_mem.delete();
  fw_mem.delete();
  m_addr_key = '0;
  m_data_key = '0;
  m_app_mode = 1'b0;
endtask

function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data,
                                            logic [3:0] strb);
  logic [31:0] res;
  res = old;
  for (int i = 0; i < 4; i++) begin
    if (strb[i]) begin
      res[8*i +: 8] = data[8*i +: 8];
    end
  end
  return res;
endfunction

// Data XOR of the scrambler at one address
function automatic logic [31:0] data_mask(logic [31:0] addr);
  return m_data_key ^ {2{addr[15:0]}};
endfunction

function automatic int phys_index(logic [31:0] addr);
  return int'(addr[RAM_AW+1:2] ^ m_addr_key);
endfunction

function automatic bit is_trap(mem_req_t r);
  return r.instr && m_app_mode && (r.addr[31:30] != AREA_RAM);
endfunction

// Targets answered by a core, two cycles after valid
function automatic bit is_core_hit(mem_req_t r);
  if (is_trap(r)) begin
    return 1'b0;
  end
  if (r.addr[31:30] == AREA_RAM) begin
    return 1'b1;
  end
  return (r.addr[31:30] == AREA_MMIO) &&
         (r.addr[29:24] inside {CORE_TIMER, CORE_FW_RAM, CORE_SYS_CTRL});
endfunction

// Applies one request to the model, gives the read data to compare
function automatic void model_access(input mem_req_t r, output bit check,
                                     output logic [31:0] exp);
  logic [31:0] cur;
  int          idx;
  logic        write;
  logic [7:0]  reg_addr;

  check    = 1'b1;
  exp      = ILLEGAL_INSTR;
  write    = |r.wstrb;
  reg_addr = r.addr[9:2];
  if (!is_core_hit(r)) begin
    return;
  end

  if (r.addr[31:30] == AREA_RAM) begin
    idx = phys_index(r.addr);
    cur = app_mem.exists(idx) ? app_mem[idx] : 32'h0;
    if (write) begin
      check = 1'b0;
      app_mem[idx] = merge_bytes(cur, r.wdata ^ data_mask(r.addr), r.wstrb);
    end else begin
      exp = cur ^ data_mask(r.addr);
    end
    return;
  end

  case (r.addr[29:24])
    CORE_FW_RAM: begin
      idx = int'(r.addr[FW_AW+1:2]);
      cur = fw_mem.exists(idx) ? fw_mem[idx] : 32'h0;
      if (write) begin
        check = 1'b0;
        if (!m_app_mode) begin
          fw_mem[idx] = merge_bytes(cur, r.wdata, r.wstrb);
        end
      end else begin
        exp = m_app_mode ? 32'h0 : cur;
      end
    end
    CORE_SYS_CTRL: begin
      if (write) begin
        check = 1'b0;
        case (reg_addr)
          SYS_REG_APP_MODE: m_app_mode = 1'b1;
          SYS_REG_ADDR_KEY: begin
            if (!m_app_mode) begin
              m_addr_key = r.wdata[RAM_AW-1:0];
            end
          end
          SYS_REG_DATA_KEY: begin
            if (!m_app_mode) begin
              m_data_key = r.wdata;
            end
          end
          default: ;
        endcase
      end else begin
        case (reg_addr)
          SYS_REG_NAME:     exp = SYS_NAME;
          SYS_REG_APP_MODE: exp = {31'h0, m_app_mode};
          SYS_REG_ADDR_KEY: exp = m_app_mode ? 32'h0 : 32'(m_addr_key);
          SYS_REG_DATA_KEY: exp = m_app_mode ? 32'h0 : m_data_key;
          default:          exp = 32'h0;
        endcase
      end
    end
    // Timer values are checked against the count bound instead
    default: check = 1'b0;
  endcase
endfunction

// Count at a sample edge, one step every presc+1 edges after the start edge
function automatic int timer_expect(int load, int presc, int start_edge, int sample_edge);
  int steps;
  steps = (sample_edge - start_edge - 1) / (presc + 1);
  return (steps >= load) ? 0 : load - steps;
endfunction

`endif

// File: tb_soc.sv
// Testbench top: clock, reset, random bus requests, model checks and watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_soc
  import soc_pkg::*;
();

  localparam int RAM_AW      = 10;
  localparam int FW_AW       = 7;
  localparam int N_RAND      = 300;
  localparam int TIMER_POLLS = 300;
  localparam int READY_LIMIT = 16;
  // Fills, fw rereads, random phases, timer polls and single accesses
  localparam int NUM_REQ = (1 << RAM_AW) + 2 * (1 << FW_AW) + 7 * N_RAND + TIMER_POLLS + 64;

  logic     clk;
  logic     reset_n;
  mem_req_t bus_req;
  mem_rsp_t bus_rsp;
  logic     app_mode;
  int       cycle = 0;
  int       lat_errors = 0;
  int       data_errors = 0;
  int       other_errors = 0;

  `include "tb_soc_model.svh"

  soc_top #(
    .RAM_AW(RAM_AW),
    .FW_AW(FW_AW)
  ) dut0 (
    .clk(clk),
    .reset_n(reset_n),
    .bus_req(bus_req),
    .bus_rsp(bus_rsp),
    .app_mode(app_mode)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // Edge count for latency and timer bounds
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] mmio_addr(logic [5:0] core, logic [7:0] reg_addr);
    return {AREA_MMIO, core, 14'h0, reg_addr, 2'b00};
  endfunction

  // Initial fill that differs for every address
  function automatic logic [31:0] fill_word(logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'hc3a5_0f1e;
  endfunction

  // Reset held for 5 cycles and released just after an edge
  task automatic apply_reset();
    reset_n = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;
  endtask

  // --------------------------------------------------
  // One transfer, held until ready
  // --------------------------------------------------
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, input logic instr,
                            output logic [31:0] rdata, output int ret_edge);
    mem_req_t    req;
    bit          check;
    logic [31:0] exp;
    int          want_lat;
    int          lat;

    req = '{valid: 1'b1, instr: instr, addr: addr, wdata: wdata, wstrb: wstrb};
    want_lat = is_core_hit(req) ? 2 : 1;
    model_access(req, check, exp);
    bus_req = req;
    lat = 0;
    do begin
      @(posedge clk);
      #1;
      lat++;
    end while (!bus_rsp.ready && lat < READY_LIMIT);
    rdata         = bus_rsp.rdata;
    ret_edge      = cycle;
    bus_req.valid = 1'b0;

    assert (bus_rsp.ready) else begin
      other_errors++;
      $display("%0t: no ready within %0d cycles for address %h", $time, READY_LIMIT, addr);
    end
    if (bus_rsp.ready) begin
      assert (lat == want_lat) else begin
        lat_errors++;
        $display("[FAIL] %0t: latency %0d, expected %0d, address %h",
                 $time, lat, want_lat, addr);
      end
      if (check) begin
        assert (rdata == exp) else begin
          data_errors++;
          $display("[FAIL] %0t: read %h, expected %h, address %h", $time, rdata, exp, addr);
        end
      end
    end

    // Idle cycle after the single ready pulse
    @(posedge clk);
    #1;
    assert (!bus_rsp.ready) else begin
      other_errors++;
      $display("%0t: ready stayed high after the transfer at address %h", $time, addr);
    end
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    logic [31:0] rd;
    int          e;
    bus_access(addr, data, strb, 1'b0, rd, e);
  endtask

  task automatic read_word(input logic [31:0] addr, output logic [31:0] rd, output int e);
    bus_access(addr, 32'h0, 4'h0, 1'b0, rd, e);
  endtask

  // --------------------------------------------------
  // Random phases
  // --------------------------------------------------
  // RAM area with aliases and an even mix of reads and strobed writes
  task automatic random_ram(input int n);
    logic [31:0] rd;
    logic [3:0]  strb;
    int          e;
    for (int i = 0; i < n; i++) begin
      strb = ($urandom % 2 == 0) ? 4'h0 : 4'($urandom);
      bus_access(32'h4000_0000 | ($urandom & 32'h3fff_fffc), $urandom, strb, 1'b0, rd, e);
    end
  endtask

  task automatic random_fw(input int n);
    logic [31:0] rd;
    logic [3:0]  strb;
    int          e;
    for (int i = 0; i < n; i++) begin
      strb = ($urandom % 2 == 0) ? 4'h0 : 4'($urandom);
      bus_access(32'hd000_0000 | ($urandom & 32'h00ff_fffc), $urandom, strb, 1'b0, rd, e);
    end
  endtask

  // ROM, reserved area and core prefixes with no core behind them
  task automatic random_unmapped(input int n);
    logic [31:0] addr;
    logic [31:0] rd;
    logic [5:0]  core;
    int          e;
    for (int i = 0; i < n; i++) begin
      case ($urandom % 3)
        0: addr = {AREA_ROM, 30'($urandom)};
        1: addr = {AREA_RESERVED, 30'($urandom)};
        default: begin
          do begin
            core = 6'($urandom);
          end while (core inside {CORE_TIMER, CORE_FW_RAM, CORE_SYS_CTRL});
          addr = {AREA_MMIO, core, 24'($urandom)};
        end
      endcase
      bus_access(addr & 32'hffff_fffc, $urandom, 4'($urandom), 1'b0, rd, e);
    end
  endtask

  task automatic random_fetch(input int n);
    logic [31:0] rd;
    int          e;
    for (int i = 0; i < n; i++) begin
      bus_access({2'($urandom), 30'($urandom)} & 32'hffff_fffc, 32'h0, 4'h0, 1'b1, rd, e);
    end
  endtask

  // New keys and their read back
  task automatic change_keys();
    logic [31:0] rd;
    int          e;
    write_word(mmio_addr(CORE_SYS_CTRL, SYS_REG_ADDR_KEY), $urandom, 4'hf);
    write_word(mmio_addr(CORE_SYS_CTRL, SYS_REG_DATA_KEY), $urandom, 4'hf);
    read_word(mmio_addr(CORE_SYS_CTRL, SYS_REG_ADDR_KEY), rd, e);
    read_word(mmio_addr(CORE_SYS_CTRL, SYS_REG_DATA_KEY), rd, e);
  endtask

  // --------------------------------------------------
  // Timer run down to zero
  // --------------------------------------------------
  task automatic timer_test();
    logic [31:0] presc;
    logic [31:0] load;
    logic [31:0] val;
    logic [31:0] prev;
    int          start_edge;
    int          e;
    int          exp;
    int          polls;

    presc = $urandom % 4;
    load  = 20 + $urandom % 40;
    write_word(mmio_addr(CORE_TIMER, TMR_PRESCALER), presc, 4'hf);
    write_word(mmio_addr(CORE_TIMER, TMR_TIMER), load, 4'hf);
    bus_access(mmio_addr(CORE_TIMER, TMR_CTRL), 32'h1, 4'hf, 1'b0, val, start_edge);
    // Write lands on the edge before ready
    start_edge = start_edge - 1;
    read_word(mmio_addr(CORE_TIMER, TMR_STATUS), val, e);
    assert (val == 32'h1) else begin
      data_errors++;
      $display("[FAIL] %0t: timer status %h after start, expected running", $time, val);
    end

    prev  = load;
    polls = 0;
    do begin
      read_word(mmio_addr(CORE_TIMER, TMR_TIMER), val, e);
      exp = timer_expect(int'(load), int'(presc), start_edge, e - 1);
      assert (val <= prev) else begin
        data_errors++;
        $display("[FAIL] %0t: timer rose from %0d to %0d", $time, prev, val);
      end
      assert (int'(val) >= exp - 1 && int'(val) <= exp + 1) else begin
        data_errors++;
        $display("[FAIL] %0t: timer %0d, expected about %0d", $time, val, exp);
      end
      prev = val;
      polls++;
    end while (val != 32'h0 && polls < TIMER_POLLS);
    assert (val == 32'h0) else begin
      other_errors++;
      $display("%0t: timer did not reach zero within %0d reads", $time, TIMER_POLLS);
    end

    read_word(mmio_addr(CORE_TIMER, TMR_STATUS), val, e);
    assert (val == 32'h0) else begin
      data_errors++;
      $display("[FAIL] %0t: timer status %h at zero, expected stopped", $time, val);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : main
    logic [31:0] rd;
    logic [31:0] addr;
    int          e;

    bus_req = '0;
    reset_n = 1'b0;
    void'($urandom(32'h9edc));
    model_reset();
    apply_reset();
    assert (bus_rsp == '0 && app_mode == 1'b0) else begin
      other_errors++;
      $display("[FAIL] %0t: response %h or app_mode %b not cleared", $time, bus_rsp, app_mode);
    end

    read_word(mmio_addr(CORE_SYS_CTRL, SYS_REG_NAME), rd, e);
    read_word(mmio_addr(CORE_SYS_CTRL, SYS_REG_APP_MODE), rd, e);
    read_word(mmio_addr(CORE_SYS_CTRL, SYS_REG_ADDR_KEY), rd, e);
    read_word(mmio_addr(CORE_SYS_CTRL, SYS_REG_DATA_KEY), rd, e);

    // Known contents everywhere while the keys are zero
    for (int w = 0; w < (1 << RAM_AW); w++) begin
      addr = 32'h4000_0000 | 32'(w << 2);
      write_word(addr, fill_word(addr), 4'hf);
    end
    for (int w = 0; w < (1 << FW_AW); w++) begin
      addr = 32'hd000_0000 | 32'(w << 2);
      write_word(addr, fill_word(addr), 4'hf);
    end

    random_ram(N_RAND);
    change_keys();
    random_ram(N_RAND);
    random_unmapped(N_RAND);
    random_fw(N_RAND);
    timer_test();

    // Application mode from here on
    write_word(mmio_addr(CORE_SYS_CTRL, SYS_REG_APP_MODE), 32'h0, 4'h1);
    assert (app_mode == 1'b1) else begin
      other_errors++;
      $display("[FAIL] %0t: app_mode output %b after mode write", $time, app_mode);
    end
    random_fw(N_RAND / 2);
    change_keys();
    random_ram(N_RAND);
    random_fetch(N_RAND);

    // Second reset clears mode and keys but not the RAM contents
    apply_reset();
    m_app_mode = 1'b0;
    m_addr_key = '0;
    m_data_key = '0;
    assert (app_mode == 1'b0) else begin
      other_errors++;
      $display("[FAIL] %0t: app_mode output %b after second reset", $time, app_mode);
    end
    // Firmware RAM must still hold only what firmware mode wrote
    for (int w = 0; w < (1 << FW_AW); w++) begin
      read_word(32'hd000_0000 | 32'(w << 2), rd, e);
    end

    $display("Errors: %0d latency, %0d data, %0d other", lat_errors, data_errors, other_errors);
    if (lat_errors + data_errors + other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (NUM_REQ * 20 + 2000) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run stopped", cycle);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
soc_pkg.sv
mem_bus_ctrl.sv
app_ram.sv
fw_ram.sv
timer.sv
sys_ctrl.sv
soc_top.sv
tb_soc.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the SoC fabric testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --top-module tb_soc -f flist.f -Mdir "$OBJ" -o tb_soc_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_soc_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
